//--- rtl/i2s_cfg_consts.svh
// I2S config block constants: bus widths, divider width and synchronizer depth

`ifndef I2S_CFG_CONSTS_SVH
`define I2S_CFG_CONSTS_SVH

//////////////////////////////////////////////////////////////////////
// Register bus
//////////////////////////////////////////////////////////////////////

// Data word on the config bus
`define CFG_DATA_W 32

// Word address, 0x20..0x2C map to 8..11
`define CFG_ADDR_W 5

//////////////////////////////////////////////////////////////////////
// Clock setup
//////////////////////////////////////////////////////////////////////

`define CLK_DIV_W 8    // One divider byte

// Flops between the clk_i toggle and the periph_clk_i edge detect
`define SYNC_STAGES 2

`endif

//--- rtl/i2s_cfg_pkg.sv
// I2S config types: register addresses and field layouts of the setup registers

`default_nettype none

`include "i2s_cfg_consts.svh"

package i2s_cfg_pkg;

    // Decoded register select
    typedef enum logic [`CFG_ADDR_W-1:0]
    {
        REG_CLKCFG    = 5'h08,
        REG_SLV_SETUP = 5'h09,
        REG_MST_SETUP = 5'h0A,
        REG_PDM_SETUP = 5'h0B,
        REG_NONE      = 5'h1F    // Any unmapped address
    } reg_addr_e;

    //////////////////////////////////////////////////////////////////////
    // Field layouts, MSB first
    //////////////////////////////////////////////////////////////////////

    typedef struct packed
    {
        logic                  master_sel_num;
        logic                  master_sel_ext;
        logic                  slave_sel_num;
        logic                  slave_sel_ext;
        logic                  rsvd;            // Bit 27
        logic                  pdm_clk_en;
        logic                  master_clk_en;
        logic                  slave_clk_en;
        logic [`CLK_DIV_W-1:0] common_div;
        logic [`CLK_DIV_W-1:0] slave_div;
        logic [`CLK_DIV_W-1:0] master_div;
    } clkcfg_t;

    // Shared by slave and master
    typedef struct packed
    {
        logic        en;
        logic [12:0] rsvd0;
        logic        ch2;
        logic        lsb_first;
        logic  [2:0] rsvd1;
        logic  [4:0] bits_word;
        logic  [4:0] rsvd2;
        logic  [2:0] words;
    } i2s_setup_t;

    typedef struct packed
    {
        logic        en;
        logic [15:0] rsvd;
        logic  [1:0] mode;
        logic  [9:0] decimation;
        logic  [2:0] shift;
    } pdm_setup_t;

endpackage

`default_nettype wire

//--- rtl/i2s_cfg_bus_if.sv
// Decoded register access between the bus decoder and the register file

`timescale 1ns/10ps
`default_nettype none

`include "i2s_cfg_consts.svh"

interface i2s_cfg_bus_if;
    import i2s_cfg_pkg::*;

    logic                   wr;     // One cycle per write
    logic                   rd;     // Level while reading
    reg_addr_e              sel;
    logic [`CFG_DATA_W-1:0] wdata;

    modport decoder
    (
        output wr, rd, sel, wdata
    );

    modport regs
    (
        input  wr, rd, sel, wdata
    );

endinterface

`default_nettype wire

//--- rtl/i2s_cfg_decode.sv
// Config bus decoder: qualifies the strobes and maps the address to a register

`timescale 1ns/10ps
`default_nettype none

`include "i2s_cfg_consts.svh"

module i2s_cfg_decode
(
    input  logic                   cfg_valid_i,
    input  logic                   cfg_rwn_i,
    input  logic [`CFG_ADDR_W-1:0] cfg_addr_i,
    input  logic [`CFG_DATA_W-1:0] cfg_data_i,
    i2s_cfg_bus_if.decoder         bus_o
);
    import i2s_cfg_pkg::*;

    assign bus_o.wr    = cfg_valid_i & ~cfg_rwn_i;
    assign bus_o.rd    = cfg_valid_i &  cfg_rwn_i;
    assign bus_o.wdata = cfg_data_i;

    // Address map
    always_comb
    begin
        case (cfg_addr_i)
            REG_CLKCFG,
            REG_SLV_SETUP,
            REG_MST_SETUP,
            REG_PDM_SETUP:
            begin
                bus_o.sel = reg_addr_e'(cfg_addr_i);
            end
            default:
            begin
                bus_o.sel = REG_NONE;  // DMA and DSP slots land here too
            end
        endcase
    end

endmodule

`default_nettype wire

//--- rtl/i2s_setup_regs.sv
// I2S setup register file with clock-enable write lock and clock update pulse

`timescale 1ns/10ps
`default_nettype none

`include "i2s_cfg_consts.svh"

module i2s_setup_regs
(
    input  logic                    clk_i,
    input  logic                    rstn_i,
    i2s_cfg_bus_if.regs             bus_i,
    output logic [`CFG_DATA_W-1:0]  rdata_o,
    output i2s_cfg_pkg::clkcfg_t    clkcfg_o,
    output logic                    upd_pulse_o,
    output i2s_cfg_pkg::i2s_setup_t slv_setup_o,
    output i2s_cfg_pkg::i2s_setup_t mst_setup_o,
    output i2s_cfg_pkg::pdm_setup_t pdm_setup_o
);
    import i2s_cfg_pkg::*;

    clkcfg_t    clkcfg_q;
    i2s_setup_t slv_setup_q;
    i2s_setup_t mst_setup_q;
    pdm_setup_t pdm_setup_q;
    logic       upd_pulse_q;

    logic       wr_clkcfg;
    logic       wr_slv;
    logic       wr_mst;
    logic       wr_pdm;

    //////////////////////////////////////////////////////////////////////
    // Reserved bits are dropped on the way in
    //////////////////////////////////////////////////////////////////////

    function automatic clkcfg_t mask_clkcfg(input logic [`CFG_DATA_W-1:0] data);
        clkcfg_t res;
        res      = clkcfg_t'(data);
        res.rsvd = 1'b0;
        return res;
    endfunction

    function automatic i2s_setup_t mask_i2s(input logic [`CFG_DATA_W-1:0] data);
        i2s_setup_t res;
        res       = i2s_setup_t'(data);
        res.rsvd0 = '0;
        res.rsvd1 = '0;
        res.rsvd2 = '0;
        return res;
    endfunction

    function automatic pdm_setup_t mask_pdm(input logic [`CFG_DATA_W-1:0] data);
        pdm_setup_t res;
        res      = pdm_setup_t'(data);
        res.rsvd = '0;
        return res;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Write enables
    //////////////////////////////////////////////////////////////////////

    // Slave clock running locks slave and PDM setup
    assign wr_clkcfg = bus_i.wr && (bus_i.sel == REG_CLKCFG);
    assign wr_slv    = bus_i.wr && (bus_i.sel == REG_SLV_SETUP) && !clkcfg_q.slave_clk_en;
    assign wr_mst    = bus_i.wr && (bus_i.sel == REG_MST_SETUP) && !clkcfg_q.master_clk_en;
    assign wr_pdm    = bus_i.wr && (bus_i.sel == REG_PDM_SETUP) && !clkcfg_q.slave_clk_en;

    always_ff @(posedge clk_i, negedge rstn_i)
    begin
        if (~rstn_i)
        begin
            clkcfg_q    <= '0;
            slv_setup_q <= '0;
            mst_setup_q <= '0;
            pdm_setup_q <= '0;
            upd_pulse_q <= 1'b0;
        end
        else
        begin
            upd_pulse_q <= wr_clkcfg;   // Trails the write by one cycle
            if (wr_clkcfg)
            begin
                clkcfg_q <= mask_clkcfg(bus_i.wdata);
            end
            if (wr_slv)
            begin
                slv_setup_q <= mask_i2s(bus_i.wdata);
            end
            if (wr_mst)
            begin
                mst_setup_q <= mask_i2s(bus_i.wdata);
            end
            if (wr_pdm)
            begin
                pdm_setup_q <= mask_pdm(bus_i.wdata);
            end
        end
    end

    // Readback
    always_comb
    begin
        rdata_o = '0;
        if (bus_i.rd)
        begin
            case (bus_i.sel)
                REG_CLKCFG:    rdata_o = clkcfg_q;
                REG_SLV_SETUP: rdata_o = slv_setup_q;
                REG_MST_SETUP: rdata_o = mst_setup_q;
                REG_PDM_SETUP: rdata_o = pdm_setup_q;
                default:       rdata_o = '0;
            endcase
        end
    end

    assign clkcfg_o    = clkcfg_q;
    assign upd_pulse_o = upd_pulse_q;
    assign slv_setup_o = slv_setup_q;
    assign mst_setup_o = mst_setup_q;
    assign pdm_setup_o = pdm_setup_q;

endmodule

`default_nettype wire

//--- rtl/i2s_clk_cdc.sv
// Clock setup transfer from clk_i into periph_clk_i by toggle synchronizer

`timescale 1ns/10ps
`default_nettype none

`include "i2s_cfg_consts.svh"

module i2s_clk_cdc
(
    input  logic                 clk_i,
    input  logic                 periph_clk_i,
    input  logic                 rstn_i,
    input  logic                 upd_pulse_i,
    input  i2s_cfg_pkg::clkcfg_t clkcfg_i,
    output i2s_cfg_pkg::clkcfg_t per_clkcfg_o
);
    import i2s_cfg_pkg::*;

    logic                    tog_q;
    logic [`SYNC_STAGES-1:0] sync_q;
    logic                    sync_prev_q;
    logic                    per_upd;
    clkcfg_t                 per_clkcfg_q;

    //////////////////////////////////////////////////////////////////////
    // clk_i side
    //////////////////////////////////////////////////////////////////////

    // One flip per update pulse
    always_ff @(posedge clk_i, negedge rstn_i)
    begin
        if (~rstn_i)
        begin
            tog_q <= 1'b0;
        end
        else if (upd_pulse_i)
        begin
            tog_q <= ~tog_q;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // periph_clk_i side
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge periph_clk_i, negedge rstn_i)
    begin
        if (~rstn_i)
        begin
            sync_q      <= '0;
            sync_prev_q <= 1'b0;
        end
        else
        begin
            sync_q      <= {sync_q[`SYNC_STAGES-2:0], tog_q};
            sync_prev_q <= sync_q[`SYNC_STAGES-1];
        end
    end

    // Either edge of the synced toggle is an update
    assign per_upd = sync_q[`SYNC_STAGES-1] ^ sync_prev_q;

    // clkcfg_i has been stable since before the toggle moved
    always_ff @(posedge periph_clk_i, negedge rstn_i)
    begin
        if (~rstn_i)
        begin
            per_clkcfg_q <= '0;
        end
        else if (per_upd)
        begin
            per_clkcfg_q <= clkcfg_i;
        end
    end

    assign per_clkcfg_o = per_clkcfg_q;

endmodule

`default_nettype wire

//--- rtl/i2s_cfg_top.sv
// I2S configuration block top: bus decode, setup registers and clock setup CDC

`timescale 1ns/10ps
`default_nettype none

`include "i2s_cfg_consts.svh"

module i2s_cfg_top
(
    input  logic                     clk_i,
    input  logic                     periph_clk_i,
    input  logic                     rstn_i,

    input  logic                     cfg_valid_i,
    input  logic                     cfg_rwn_i,
    input  logic [`CFG_ADDR_W-1:0]   cfg_addr_i,
    input  logic [`CFG_DATA_W-1:0]   cfg_data_i,
    output logic [`CFG_DATA_W-1:0]   cfg_data_o,

    // periph_clk_i domain
    output logic                     master_clk_en_o,
    output logic                     slave_clk_en_o,
    output logic                     pdm_clk_en_o,
    output logic                     master_sel_num_o,
    output logic                     master_sel_ext_o,
    output logic                     slave_sel_num_o,
    output logic                     slave_sel_ext_o,
    output logic [2*`CLK_DIV_W-1:0]  slave_clk_div_o,
    output logic [2*`CLK_DIV_W-1:0]  master_clk_div_o,

    // clk_i domain
    output logic                     slave_i2s_en_o,
    output logic                     slave_i2s_2ch_o,
    output logic                     slave_i2s_lsb_first_o,
    output logic               [4:0] slave_i2s_bits_word_o,
    output logic               [2:0] slave_i2s_words_o,

    output logic                     master_i2s_en_o,
    output logic                     master_i2s_2ch_o,
    output logic                     master_i2s_lsb_first_o,
    output logic               [4:0] master_i2s_bits_word_o,
    output logic               [2:0] master_i2s_words_o,

    output logic                     pdm_en_o,
    output logic               [1:0] pdm_mode_o,
    output logic               [9:0] pdm_decimation_o,
    output logic               [2:0] pdm_shift_o
);
    import i2s_cfg_pkg::*;

    clkcfg_t    clkcfg;
    clkcfg_t    per_clkcfg;
    i2s_setup_t slv_setup;
    i2s_setup_t mst_setup;
    pdm_setup_t pdm_setup;
    logic       upd_pulse;

    i2s_cfg_bus_if bus ();

    i2s_cfg_decode u_decode
    (
        .cfg_valid_i ( cfg_valid_i ),
        .cfg_rwn_i   ( cfg_rwn_i   ),
        .cfg_addr_i  ( cfg_addr_i  ),
        .cfg_data_i  ( cfg_data_i  ),
        .bus_o       ( bus         )
    );

    i2s_setup_regs u_regs
    (
        .clk_i       ( clk_i      ),
        .rstn_i      ( rstn_i     ),
        .bus_i       ( bus        ),
        .rdata_o     ( cfg_data_o ),
        .clkcfg_o    ( clkcfg     ),
        .upd_pulse_o ( upd_pulse  ),
        .slv_setup_o ( slv_setup  ),
        .mst_setup_o ( mst_setup  ),
        .pdm_setup_o ( pdm_setup  )
    );

    i2s_clk_cdc u_clk_cdc
    (
        .clk_i        ( clk_i        ),
        .periph_clk_i ( periph_clk_i ),
        .rstn_i       ( rstn_i       ),
        .upd_pulse_i  ( upd_pulse    ),
        .clkcfg_i     ( clkcfg       ),
        .per_clkcfg_o ( per_clkcfg   )
    );

    //////////////////////////////////////////////////////////////////////
    // Field unpacking
    //////////////////////////////////////////////////////////////////////

    assign master_clk_en_o  = per_clkcfg.master_clk_en;
    assign slave_clk_en_o   = per_clkcfg.slave_clk_en;
    assign pdm_clk_en_o     = per_clkcfg.pdm_clk_en;
    assign master_sel_num_o = per_clkcfg.master_sel_num;
    assign master_sel_ext_o = per_clkcfg.master_sel_ext;
    assign slave_sel_num_o  = per_clkcfg.slave_sel_num;
    assign slave_sel_ext_o  = per_clkcfg.slave_sel_ext;
    assign slave_clk_div_o  = {per_clkcfg.common_div, per_clkcfg.slave_div};  // Common byte on top
    assign master_clk_div_o = {per_clkcfg.common_div, per_clkcfg.master_div};

    assign slave_i2s_en_o         = slv_setup.en;
    assign slave_i2s_2ch_o        = slv_setup.ch2;
    assign slave_i2s_lsb_first_o  = slv_setup.lsb_first;
    assign slave_i2s_bits_word_o  = slv_setup.bits_word;
    assign slave_i2s_words_o      = slv_setup.words;

    assign master_i2s_en_o        = mst_setup.en;
    assign master_i2s_2ch_o       = mst_setup.ch2;
    assign master_i2s_lsb_first_o = mst_setup.lsb_first;
    assign master_i2s_bits_word_o = mst_setup.bits_word;
    assign master_i2s_words_o     = mst_setup.words;

    assign pdm_en_o         = pdm_setup.en;
    assign pdm_mode_o       = pdm_setup.mode;
    assign pdm_decimation_o = pdm_setup.decimation;
    assign pdm_shift_o      = pdm_setup.shift;

endmodule

`default_nettype wire

//--- tb/i2s_cfg_assert.sv
// Setup register checks for update pulse width, idle readback and write lock

`timescale 1ns/10ps
`default_nettype none

`include "i2s_cfg_consts.svh"

module i2s_cfg_assert
(
    input  logic                    clk_i,
    input  logic                    rstn_i,
    input  logic                    wr_i,
    input  logic                    rd_i,
    input  i2s_cfg_pkg::reg_addr_e  sel_i,
    input  logic [`CFG_DATA_W-1:0]  rdata_i,
    input  logic                    upd_pulse_i,
    input  i2s_cfg_pkg::clkcfg_t    clkcfg_i,
    input  i2s_cfg_pkg::i2s_setup_t slv_i,
    input  i2s_cfg_pkg::i2s_setup_t mst_i,
    input  i2s_cfg_pkg::pdm_setup_t pdm_i
);
    import i2s_cfg_pkg::*;

    int   pulse_errs = 0;
    int   idle_errs = 0;
    int   lock_errs = 0;
    logic locked_wr;

    assign locked_wr = wr_i && ((((sel_i == REG_SLV_SETUP) || (sel_i == REG_PDM_SETUP))
                                 && clkcfg_i.slave_clk_en)
                                || ((sel_i == REG_MST_SETUP) && clkcfg_i.master_clk_en));

    assert property (@(posedge clk_i) disable iff (!rstn_i) upd_pulse_i |=> !upd_pulse_i)
    else
    begin
        $error("update pulse lasted more than one cycle");
        pulse_errs++;
    end

    assert property (@(posedge clk_i) disable iff (!rstn_i) !rd_i |-> (rdata_i == '0))
    else
    begin
        $error("readback not zero without a read");
        idle_errs++;
    end

    // Locked write leaves every setup register as it was
    assert property (@(posedge clk_i) disable iff (!rstn_i)
                     locked_wr |=> $stable({slv_i, mst_i, pdm_i}))
    else
    begin
        $error("locked setup register changed on a write");
        lock_errs++;
    end

endmodule

bind i2s_setup_regs i2s_cfg_assert u_assert
(
    .clk_i       ( clk_i       ),
    .rstn_i      ( rstn_i      ),
    .wr_i        ( bus_i.wr    ),
    .rd_i        ( bus_i.rd    ),
    .sel_i       ( bus_i.sel   ),
    .rdata_i     ( rdata_o     ),
    .upd_pulse_i ( upd_pulse_o ),
    .clkcfg_i    ( clkcfg_q    ),
    .slv_i       ( slv_setup_q ),
    .mst_i       ( mst_setup_q ),
    .pdm_i       ( pdm_setup_q )
);

`default_nettype wire

//--- tb/tb_i2s_cfg.sv
// Testbench for the I2S config block: register access, write lock and clock setup transfer

`timescale 1ns/10ps
`default_nettype none

`include "i2s_cfg_consts.svh"

module tb_i2s_cfg;
    import i2s_cfg_pkg::*;

    localparam time CLK_PER    = 20;
    localparam time PER_PER    = 28;
    localparam time N_OPS      = 200;
    localparam time TIME_LIMIT = N_OPS * 10 * CLK_PER + 2000;

    // Writable bits of each register, from the field layouts
    localparam logic [31:0] CLKCFG_MASK = 32'hF7FF_FFFF;
    localparam logic [31:0] I2S_MASK    = 32'h8003_1F07;
    localparam logic [31:0] PDM_MASK    = 32'h8000_7FFF;

    logic                   clk_i = 1'b0;
    logic                   periph_clk_i = 1'b0;
    logic                   rstn_i;
    logic                   cfg_valid_i;
    logic                   cfg_rwn_i;
    logic [`CFG_ADDR_W-1:0] cfg_addr_i;
    logic [`CFG_DATA_W-1:0] cfg_data_i;
    logic [`CFG_DATA_W-1:0] cfg_data_o;
    logic                   master_clk_en_o;
    logic                   slave_clk_en_o;
    logic                   pdm_clk_en_o;
    logic                   master_sel_num_o;
    logic                   master_sel_ext_o;
    logic                   slave_sel_num_o;
    logic                   slave_sel_ext_o;
    logic            [15:0] slave_clk_div_o;
    logic            [15:0] master_clk_div_o;
    logic                   slave_i2s_en_o;
    logic                   slave_i2s_2ch_o;
    logic                   slave_i2s_lsb_first_o;
    logic             [4:0] slave_i2s_bits_word_o;
    logic             [2:0] slave_i2s_words_o;
    logic                   master_i2s_en_o;
    logic                   master_i2s_2ch_o;
    logic                   master_i2s_lsb_first_o;
    logic             [4:0] master_i2s_bits_word_o;
    logic             [2:0] master_i2s_words_o;
    logic                   pdm_en_o;
    logic             [1:0] pdm_mode_o;
    logic             [9:0] pdm_decimation_o;
    logic             [2:0] pdm_shift_o;

    logic [31:0] model [4] = '{default: 32'h0};   // Indexed by address bits 1:0
    clkcfg_t     exp_per = '0;
    logic        per_stable = 1'b1;                // Periph copy settled
    integer      seed = 32'hdb13ecde;
    int          err_cnt = 0;
    int          late_cnt = 0;
    int          check_cnt = 0;
    int          test_cnt = 0;
    int          err_mark = 0;

    i2s_setup_t  slv_got;
    i2s_setup_t  mst_got;
    pdm_setup_t  pdm_got;

    i2s_cfg_top u_dut (.*);

    always #(CLK_PER / 2) clk_i = ~clk_i;
    always #(PER_PER / 2) periph_clk_i = ~periph_clk_i;

    assign slv_got = {slave_i2s_en_o, 13'h0, slave_i2s_2ch_o, slave_i2s_lsb_first_o, 3'h0,
                      slave_i2s_bits_word_o, 5'h0, slave_i2s_words_o};
    assign mst_got = {master_i2s_en_o, 13'h0, master_i2s_2ch_o, master_i2s_lsb_first_o, 3'h0,
                      master_i2s_bits_word_o, 5'h0, master_i2s_words_o};
    assign pdm_got = {pdm_en_o, 16'h0, pdm_mode_o, pdm_decimation_o, pdm_shift_o};

    ////////////////////////////////////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////////////////////////////////////

    // Register contents after a write, given the clock setup at that time
    function automatic logic [31:0] ref_write(input logic [4:0] addr, input logic [31:0] data,
                                              input logic [31:0] old, input clkcfg_t lock);
        logic [31:0] res;
        case (addr)
            REG_CLKCFG:    res = data & CLKCFG_MASK;
            REG_SLV_SETUP: res = lock.slave_clk_en ? old : (data & I2S_MASK);
            REG_MST_SETUP: res = lock.master_clk_en ? old : (data & I2S_MASK);
            REG_PDM_SETUP: res = lock.slave_clk_en ? old : (data & PDM_MASK);
            default:       res = old;
        endcase
        return res;
    endfunction

    function automatic logic is_mapped(input logic [4:0] addr);
        return (addr >= 5'd8) && (addr <= 5'd11);
    endfunction

    function automatic logic [31:0] ref_read(input logic [4:0] addr);
        return is_mapped(addr) ? model[addr[1:0]] : 32'h0;
    endfunction

    function automatic clkcfg_t periph_outputs();
        return {master_sel_num_o, master_sel_ext_o, slave_sel_num_o, slave_sel_ext_o, 1'b0,
                pdm_clk_en_o, master_clk_en_o, slave_clk_en_o,
                master_clk_div_o[15:8], slave_clk_div_o[7:0], master_clk_div_o[7:0]};
    endfunction

    function automatic logic [31:0] random_word();
        return $random(seed);
    endfunction

    ////////////////////////////////////////////////////////////////////////
    // Compare tasks
    ////////////////////////////////////////////////////////////////////////

    task automatic compare_word(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
        check_cnt++;
        if (got !== exp)
        begin
            $display("FAILED t=%0t %s got %h expected %h", $time, name, got, exp);
            err_cnt++;
        end
    endtask

    task automatic compare_clkcfg(input string name, input clkcfg_t got, input clkcfg_t exp);
        check_cnt++;
        if (got !== exp)
        begin
            $display("FAILED t=%0t %s got %h expected %h", $time, name, got, exp);
            err_cnt++;
        end
    endtask

    task automatic compare_i2s(input string name, input i2s_setup_t got, input i2s_setup_t exp);
        check_cnt++;
        if (got !== exp)
        begin
            $display("FAILED t=%0t %s got %h expected %h", $time, name, got, exp);
            err_cnt++;
        end
    endtask

    task automatic compare_pdm(input string name, input pdm_setup_t got, input pdm_setup_t exp);
        check_cnt++;
        if (got !== exp)
        begin
            $display("FAILED t=%0t %s got %h expected %h", $time, name, got, exp);
            err_cnt++;
        end
    endtask

    // Outputs are settled half a cycle after the driving edge
    always @(negedge clk_i)
    begin
        if (cfg_valid_i && cfg_rwn_i)
        begin
            compare_word("cfg_data_o", cfg_data_o, ref_read(cfg_addr_i));
        end
        else
        begin
            compare_word("cfg_data_o idle", cfg_data_o, 32'h0);
        end
        compare_i2s("slave setup outputs", slv_got, i2s_setup_t'(model[1]));
        compare_i2s("master setup outputs", mst_got, i2s_setup_t'(model[2]));
        compare_pdm("pdm setup outputs", pdm_got, pdm_setup_t'(model[3]));
        if (per_stable)
        begin
            compare_clkcfg("periph clock outputs", periph_outputs(), exp_per);
            compare_word("slave_clk_div_o", {16'h0, slave_clk_div_o},
                         {16'h0, exp_per.common_div, exp_per.slave_div});
        end
    end

    ////////////////////////////////////////////////////////////////////////
    // Bus access
    ////////////////////////////////////////////////////////////////////////

    task automatic write_reg(input logic [4:0] addr, input logic [31:0] data);
        @(posedge clk_i);
        cfg_valid_i <= 1'b1;
        cfg_rwn_i   <= 1'b0;
        cfg_addr_i  <= addr;
        cfg_data_i  <= data;
        @(posedge clk_i);
        cfg_valid_i <= 1'b0;   // DUT took the write on this edge
        if (is_mapped(addr))
        begin
            model[addr[1:0]] = ref_write(addr, data, model[addr[1:0]], clkcfg_t'(model[0]));
        end
    endtask

    task automatic read_reg(input logic [4:0] addr);
        @(posedge clk_i);
        cfg_valid_i <= 1'b1;
        cfg_rwn_i   <= 1'b1;
        cfg_addr_i  <= addr;
        @(posedge clk_i);
        cfg_valid_i <= 1'b0;
    endtask

    // Clock write, then wait for the periph copy with its latency bound
    task automatic write_clk(input logic [31:0] data);
        time t_end;
        per_stable = 1'b0;
        write_reg(REG_CLKCFG, data);
        t_end = $time + CLK_PER + 4 * PER_PER;
        while ((periph_outputs() !== clkcfg_t'(model[0])) && ($time < t_end))
        begin
            #1;
        end
        if (periph_outputs() !== clkcfg_t'(model[0]))
        begin
            $display("clock setup did not reach the periph domain in time (t=%0t)", $time);
            late_cnt++;
        end
        exp_per    = clkcfg_t'(model[0]);
        per_stable = 1'b1;
    endtask

    task automatic write_setups();
        write_reg(REG_SLV_SETUP, random_word());
        write_reg(REG_PDM_SETUP, random_word());
        write_reg(REG_MST_SETUP, random_word());
    endtask

    task automatic read_all();
        read_reg(REG_CLKCFG);
        read_reg(REG_SLV_SETUP);
        read_reg(REG_MST_SETUP);
        read_reg(REG_PDM_SETUP);
        read_reg(5'h00);
        read_reg(5'h1F);
    endtask

    task automatic end_test(input string name);
        test_cnt++;
        if (err_cnt + late_cnt == err_mark)
        begin
            $display("test %0d (%s): ok", test_cnt, name);
        end
        else
        begin
            $display("test %0d (%s): %0d errors", test_cnt, name, err_cnt + late_cnt - err_mark);
        end
        err_mark = err_cnt + late_cnt;
    endtask

    ////////////////////////////////////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////////////////////////////////////

    initial
    begin
        int total;
        cfg_valid_i = 1'b0;
        cfg_rwn_i   = 1'b0;
        cfg_addr_i  = '0;
        cfg_data_i  = '0;
        rstn_i      = 1'b0;
        repeat (4) @(posedge clk_i);
        rstn_i <= 1'b1;

        read_all();
        end_test("reset values");

        for (int i = 0; i < 8; i++)
        begin
            write_clk(random_word() & ~32'h0700_0000);   // All clocks off
            write_setups();
            write_reg(5'h04, random_word());              // Unmapped
            read_all();
        end
        end_test("write and readback");

        write_clk(32'h0100_0000);   // Slave clock on
        write_setups();
        read_all();
        write_clk(32'h0200_0000);   // Master clock on
        write_setups();
        read_all();
        write_clk(32'h0000_0000);
        write_setups();
        read_all();
        end_test("write lock");

        for (int i = 0; i < 6; i++)
        begin
            write_clk(random_word());
            read_reg(REG_CLKCFG);
        end
        end_test("clock setup transfer");

        write_clk(random_word() & ~32'h0300_0000);
        for (int i = 0; i < 3; i++)
        begin
            write_setups();
            read_all();
        end
        end_test("periph hold");

        repeat (2) @(posedge clk_i);
        total = err_cnt + late_cnt + u_dut.u_regs.u_assert.pulse_errs
              + u_dut.u_regs.u_assert.idle_errs + u_dut.u_regs.u_assert.lock_errs;
        $display("summary: %0d tests, %0d checks, %0d errors", test_cnt, check_cnt, total);
        if (total == 0)
        begin
            $display("all tests passed");
        end
        else
        begin
            $display("tests failed");
        end
        $finish;
    end

    // Watchdog
    initial
    begin
        #(TIME_LIMIT);
        $display("watchdog: simulation ran past its time limit");
        $display("tests failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- compile.f
+incdir+rtl
rtl/i2s_cfg_pkg.sv
rtl/i2s_cfg_bus_if.sv
rtl/i2s_cfg_decode.sv
rtl/i2s_setup_regs.sv
rtl/i2s_clk_cdc.sv
rtl/i2s_cfg_top.sv
tb/i2s_cfg_assert.sv
tb/tb_i2s_cfg.sv

//--- Makefile
TOP = tb_i2s_cfg

.PHONY: sim clean

sim:
	verilator --binary --timing --assert --timescale 1ns/10ps -f compile.f --top-module $(TOP) -o $(TOP)
	./obj_dir/$(TOP) +verilator+error+limit+100 | tee sim.log
	grep -q "all tests passed" sim.log

clean:
	rm -rf obj_dir sim.log
